/* his_pkg.sv */
package his_pkg;

    // raw tdc code from the front end
    localparam int TDC_W = 10;
    typedef logic [TDC_W-1:0] tdc_code_t;

    // first code of the time window and bin width as a shift
    localparam int WIN_START = 64;
    localparam int BIN_SHIFT = 3;

    // bins per pixel
    localparam int NUM_BINS = 16;
    localparam int BIN_W = $clog2(NUM_BINS);
    typedef logic [BIN_W-1:0] bin_t;

    // pixels per acquisition
    localparam int NUM_PIXELS = 4;
    localparam int PIXEL_W = $clog2(NUM_PIXELS);
    typedef logic [PIXEL_W-1:0] pixel_t;

    // strobes per pixel
    localparam int SAMPLES_PER_PIXEL = 8;
    localparam int SAMPLE_W = $clog2(SAMPLES_PER_PIXEL);
    typedef logic [SAMPLE_W-1:0] sample_t;

    // acquisitions per frame
    localparam int NUM_ACQ = 2;
    localparam int ACQ_W = $clog2(NUM_ACQ);
    typedef logic [ACQ_W-1:0] acq_t;

    // one bank holds every bin of every pixel
    // word address is pixel * NUM_BINS + bin
    localparam int HIS_DEPTH = NUM_PIXELS * NUM_BINS;
    localparam int HIS_ADDR_W = $clog2(HIS_DEPTH);
    typedef logic [HIS_ADDR_W-1:0] his_addr_t;

    // clear walk covers both banks and needs one extra bit
    localparam int CLEAR_WORDS = 2 * HIS_DEPTH;
    typedef logic [HIS_ADDR_W:0] clr_cnt_t;

    // saturating bin count
    localparam int COUNT_W = 8;
    typedef logic [COUNT_W-1:0] count_t;
    localparam count_t COUNT_MAX = '1;

    // readout engine phase
    typedef enum logic [1:0] {
        ro_clear,
        ro_idle,
        ro_stream
    } ro_phase_t;

endpackage

/* his_ram_if.sv */
`timescale 1ns/10ps

// one histogram memory port
// en reads {bank, addr}, rdata follows one cycle later
// we writes wdata back to the word read on the previous cycle
interface his_ram_if import his_pkg::*; ();

    logic      en;
    logic      we;
    logic      bank;
    his_addr_t addr;
    count_t    wdata;
    count_t    rdata;

    // builder or readout side
    modport master (
        output en, we, bank, addr, wdata,
        input  rdata
    );

    // memory side
    modport memory (
        input  en, we, bank, addr, wdata,
        output rdata
    );

endinterface

/* bin_mapper.sv */
`timescale 1ns/10ps

module bin_mapper import his_pkg::*; (
    input  logic      clk,
    input  logic      res,
    input  logic      tdc_valid,
    input  tdc_code_t tdc_code,
    output logic      hit_valid,
    output logic      hit_in_window,
    output bin_t      hit_bin
);

    // code relative to window start
    tdc_code_t offset;
    // offset in bin units
    tdc_code_t shifted;
    logic      in_window;

    always_comb begin
        offset  = tdc_code - tdc_code_t'(WIN_START);
        shifted = offset >> BIN_SHIFT;
        // below start wraps around, so check the raw code too
        in_window = (tdc_code >= tdc_code_t'(WIN_START)) &&
                    (shifted < tdc_code_t'(NUM_BINS));
    end

    // every strobe is forwarded whether in window or not
    // builder needs all of them to keep its sample count exact
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hit_valid <= 1'b0;
        end else begin
            hit_valid <= tdc_valid;
        end
    end

    // window flag and bin of the strobe
    always_ff @(posedge clk) begin
        if (tdc_valid) begin
            hit_in_window <= in_window;
            hit_bin       <= shifted[BIN_W-1:0];
        end
    end

endmodule

/* his_builder.sv */
`timescale 1ns/10ps

module his_builder import his_pkg::*; (
    input  logic      clk,
    input  logic      res,
    input  logic      hit_valid,
    input  logic      hit_in_window,
    input  bin_t      hit_bin,
    his_ram_if.master ram,
    output logic      bank,
    output logic      frame_done
);

    // nested counters for sample inside pixel inside acquisition
    sample_t sample_cnt;
    pixel_t  pixel_cnt;
    acq_t    acq_cnt;
    logic    last_sample;
    logic    last_pixel;
    logic    last_acq;
    logic    last_hit;

    // bank for new reads flips on the last hit itself
    logic act_bank;

    // write stage one cycle behind the read
    logic      st_valid;
    logic      st_last;
    logic      st_bank;
    his_addr_t st_addr;

    // copy of the word written last cycle
    logic      fw_valid;
    logic      fw_bank;
    his_addr_t fw_addr;
    count_t    fw_data;
    logic      fw_hit;
    count_t    cur_count;

    assign last_sample = (sample_cnt == sample_t'(SAMPLES_PER_PIXEL - 1));
    assign last_pixel  = (pixel_cnt == pixel_t'(NUM_PIXELS - 1));
    assign last_acq    = (acq_cnt == acq_t'(NUM_ACQ - 1));
    assign last_hit    = hit_valid && last_sample && last_pixel && last_acq;

    // read request straight from the mapper output
    assign ram.en   = hit_valid && hit_in_window;
    assign ram.bank = act_bank;
    assign ram.addr = {pixel_cnt, hit_bin};

    // memory has not yet absorbed last cycle's write, so take it from here
    assign fw_hit    = fw_valid && (fw_addr == st_addr) && (fw_bank == st_bank);
    assign cur_count = fw_hit ? fw_data : ram.rdata;

    // increment that sticks at full scale
    assign ram.we    = st_valid;
    assign ram.wdata = (cur_count == COUNT_MAX) ? cur_count : cur_count + count_t'(1);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sample_cnt <= '0;
            pixel_cnt  <= '0;
            acq_cnt    <= '0;
            act_bank   <= 1'b0;
        end else if (hit_valid) begin
            sample_cnt <= last_sample ? '0 : sample_cnt + sample_t'(1);
            if (last_sample) begin
                pixel_cnt <= last_pixel ? '0 : pixel_cnt + pixel_t'(1);
                if (last_pixel) begin
                    acq_cnt <= last_acq ? '0 : acq_cnt + acq_t'(1);
                end
            end
            // next frame reads already land in the fresh bank
            if (last_hit) begin
                act_bank <= ~act_bank;
            end
        end
    end

    // stage and forward valid bits plus frame end flags
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            st_valid   <= 1'b0;
            st_last    <= 1'b0;
            fw_valid   <= 1'b0;
            frame_done <= 1'b0;
            bank       <= 1'b0;
        end else begin
            st_valid   <= ram.en;
            // out-of-window last sample still ends the frame
            st_last    <= last_hit;
            fw_valid   <= st_valid;
            frame_done <= st_last;
            if (st_last) begin
                bank <= ~bank;
            end
        end
    end

    // address and data payload
    always_ff @(posedge clk) begin
        st_addr <= ram.addr;
        st_bank <= act_bank;
        fw_addr <= st_addr;
        fw_bank <= st_bank;
        fw_data <= ram.wdata;
    end

endmodule

/* his_ram.sv */
`timescale 1ns/10ps

module his_ram import his_pkg::*; (
    input  logic      clk,
    his_ram_if.memory bp,
    his_ram_if.memory rp
);

    // two banks of bin counts
    count_t mem [2][HIS_DEPTH];

    // location of the last read on each port
    // a write in the following cycle goes back there
    logic      bp_bank_q;
    his_addr_t bp_addr_q;
    logic      rp_bank_q;
    his_addr_t rp_addr_q;

    // builder port
    // read and write may both be active in one cycle at different words
    always_ff @(posedge clk) begin
        if (bp.en) begin
            bp.rdata  <= mem[bp.bank][bp.addr];
            bp_bank_q <= bp.bank;
            bp_addr_q <= bp.addr;
        end
        if (bp.we) begin
            mem[bp_bank_q][bp_addr_q] <= bp.wdata;
        end

        // readout port with the same read then write-back scheme
        if (rp.en) begin
            rp.rdata  <= mem[rp.bank][rp.addr];
            rp_bank_q <= rp.bank;
            rp_addr_q <= rp.addr;
        end
        if (rp.we) begin
            mem[rp_bank_q][rp_addr_q] <= rp.wdata;
        end
    end

    // read of a word being written returns the old value
    // builder covers that case with its forward path

endmodule

/* his_readout.sv */
`timescale 1ns/10ps

module his_readout import his_pkg::*; (
    input  logic      clk,
    input  logic      res,
    input  logic      frame_done,
    input  logic      bank,
    his_ram_if.master ram,
    output logic      ready,
    output logic      out_valid,
    output pixel_t    out_pixel,
    output bin_t      out_bin,
    output count_t    out_count
);

    ro_phase_t phase;
    // word counter whose top bit picks the bank while clearing
    clr_cnt_t  cnt;
    // bank being streamed
    logic      ro_bank;
    // a read went out last cycle, so its word gets cleared now
    logic      wr_pend;
    // address of the word now on rdata
    his_addr_t out_addr;

    assign ram.en    = (phase != ro_idle);
    assign ram.bank  = (phase == ro_clear) ? cnt[HIS_ADDR_W] : ro_bank;
    assign ram.addr  = cnt[HIS_ADDR_W-1:0];
    // every word read is zeroed behind the read
    assign ram.we    = wr_pend;
    assign ram.wdata = '0;

    assign {out_pixel, out_bin} = out_addr;
    assign out_count = ram.rdata;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase     <= ro_clear;
            cnt       <= '0;
            ro_bank   <= 1'b0;
            ready     <= 1'b0;
            wr_pend   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            wr_pend   <= ram.en;
            out_valid <= (phase == ro_stream);
            case (phase)
                ro_clear: begin
                    // walk both banks once after reset
                    cnt <= cnt + clr_cnt_t'(1);
                    if (cnt == clr_cnt_t'(CLEAR_WORDS - 1)) begin
                        cnt   <= '0;
                        ready <= 1'b1;
                        phase <= ro_idle;
                    end
                end
                ro_idle: begin
                    // bank has already flipped so the old one is the other
                    if (frame_done) begin
                        ro_bank <= ~bank;
                        cnt     <= '0;
                        phase   <= ro_stream;
                    end
                end
                ro_stream: begin
                    // next frame may end on the last read of this one
                    if (frame_done) begin
                        ro_bank <= ~bank;
                        cnt     <= '0;
                    end else if (cnt[HIS_ADDR_W-1:0] == his_addr_t'(HIS_DEPTH - 1)) begin
                        cnt   <= '0;
                        phase <= ro_idle;
                    end else begin
                        cnt <= cnt + clr_cnt_t'(1);
                    end
                end
                default: begin
                    phase <= ro_idle;
                end
            endcase
        end
    end

    // word address follows rdata by one cycle
    always_ff @(posedge clk) begin
        out_addr <= ram.addr;
    end

endmodule

/* his_top.sv */
`timescale 1ns/10ps

module his_top import his_pkg::*; (
    input  logic      clk,
    input  logic      res,
    input  logic      tdc_valid,
    input  tdc_code_t tdc_code,
    output logic      ready,
    output logic      frame_done,
    output logic      bank,
    output logic      out_valid,
    output pixel_t    out_pixel,
    output bin_t      out_bin,
    output count_t    out_count
);

    // mapper to builder
    logic hit_valid;
    logic hit_in_window;
    bin_t hit_bin;

    // builder port on the active bank
    his_ram_if b_ram ();
    // readout port on the finished bank
    his_ram_if r_ram ();

    bin_mapper bin_mapper_i (
        .clk           (clk),
        .res           (res),
        .tdc_valid     (tdc_valid),
        .tdc_code      (tdc_code),
        .hit_valid     (hit_valid),
        .hit_in_window (hit_in_window),
        .hit_bin       (hit_bin)
    );

    his_builder his_builder_i (
        .clk           (clk),
        .res           (res),
        .hit_valid     (hit_valid),
        .hit_in_window (hit_in_window),
        .hit_bin       (hit_bin),
        .ram           (b_ram.master),
        .bank          (bank),
        .frame_done    (frame_done)
    );

    his_ram his_ram_i (
        .clk (clk),
        .bp  (b_ram.memory),
        .rp  (r_ram.memory)
    );

    // streams and clears the bank the builder just left
    his_readout his_readout_i (
        .clk        (clk),
        .res        (res),
        .frame_done (frame_done),
        .bank       (bank),
        .ram        (r_ram.master),
        .ready      (ready),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_bin    (out_bin),
        .out_count  (out_count)
    );

endmodule

/* tb_his_top.sv */
`timescale 1ns/10ps

module tb_his_top import his_pkg::*; ();

    localparam int NUM_FRAMES    = 8;
    localparam int FRAME_SAMPLES = SAMPLES_PER_PIXEL * NUM_PIXELS * NUM_ACQ;
    // clear walk plus worst case gaps and one readout per frame
    localparam int TIMEOUT_CYCLES = 128 + NUM_FRAMES * (FRAME_SAMPLES * 4 + 80) + 200;
    // a pixel sees its samples once per acquisition
    localparam count_t MAX_FRAME_COUNT = count_t'(SAMPLES_PER_PIXEL * NUM_ACQ);

    logic      clk = 1'b0;
    logic      res;
    logic      tdc_valid;
    tdc_code_t tdc_code;
    logic      ready;
    logic      frame_done;
    logic      bank;
    logic      out_valid;
    pixel_t    out_pixel;
    bin_t      out_bin;
    count_t    out_count;

    // expected histogram per frame
    count_t exp_hist [NUM_FRAMES][HIS_DEPTH];

    int   val_errs = 0;
    int   stream_errs = 0;
    int   frame_errs = 0;
    int   cyc = 0;
    // position inside the current stream and the frame it belongs to
    int   word_cnt = 0;
    int   ro_frame = 0;
    int   samples_seen = 0;
    int   done_cnt = 0;
    logic exp_bank = 1'b0;
    logic fd_prev = 1'b0;

    his_top his_top_i (
        .clk        (clk),
        .res        (res),
        .tdc_valid  (tdc_valid),
        .tdc_code   (tdc_code),
        .ready      (ready),
        .frame_done (frame_done),
        .bank       (bank),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_bin    (out_bin),
        .out_count  (out_count)
    );

    always #5 clk = ~clk;

    // window is WIN_START up to NUM_BINS bins of 2**BIN_SHIFT codes
    // returns {in_window, bin}
    function automatic logic [BIN_W:0] ref_bin(input tdc_code_t code);
        int c;
        int last_code;
        logic [BIN_W:0] r;
        c = int'(code);
        last_code = WIN_START + (NUM_BINS << BIN_SHIFT) - 1;
        r = '0;
        if (c >= WIN_START && c <= last_code) begin
            r = {1'b1, bin_t'((c - WIN_START) >> BIN_SHIFT)};
        end
        return r;
    endfunction

    // stimulus per frame number
    function automatic tdc_code_t frame_code(input int f);
        tdc_code_t code;
        if (f == 2) begin
            code = tdc_code_t'(100);
        end else if (f == 4) begin
            code = tdc_code_t'(170);
        end else if (f == 3) begin
            // below the window only
            code = tdc_code_t'($urandom_range(0, WIN_START - 1));
        end else if (f == 5) begin
            // above the window only
            code = tdc_code_t'($urandom_range(WIN_START + (NUM_BINS << BIN_SHIFT), 1023));
        end else if ((f == 1 || f == 6) && $urandom_range(0, 3) != 0) begin
            code = tdc_code_t'(WIN_START + $urandom_range(0, 127));
        end else begin
            code = tdc_code_t'($urandom_range(0, 1023));
        end
        return code;
    endfunction

    task automatic check_count(input count_t got, input count_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: out_count got %0d expected %0d", $time, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_index(input pixel_t got_p, input bin_t got_b,
                               input pixel_t exp_p, input bin_t exp_b);
        if (got_p !== exp_p) begin
            $display("Fail at %0t: out_pixel got %0d expected %0d", $time, got_p, exp_p);
            val_errs++;
        end
        if (got_b !== exp_b) begin
            $display("Fail at %0t: out_bin got %0d expected %0d", $time, got_b, exp_b);
            val_errs++;
        end
    endtask

    task automatic check_bank(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: bank got %0b expected %0b", $time, got, exp);
            val_errs++;
        end
    endtask

    // one sample after a gap of idle cycles
    task automatic send_sample(input tdc_code_t code, input int gap);
        repeat (gap) begin
            @(posedge clk);
            tdc_valid <= 1'b0;
        end
        @(posedge clk);
        tdc_valid <= 1'b1;
        tdc_code  <= code;
    endtask

    always @(posedge clk) begin
        cyc++;
        if (cyc > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d frames streamed",
                     cyc, ro_frame, NUM_FRAMES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // stream compare on the falling edge
    always @(negedge clk) begin
        if (res === 1'b1) begin
            if (out_valid) begin
                if (ro_frame >= NUM_FRAMES) begin
                    $display("stream words seen at %0t with no frame left to read", $time);
                    stream_errs++;
                end else begin
                    check_index(out_pixel, out_bin, pixel_t'(word_cnt / NUM_BINS),
                                bin_t'(word_cnt % NUM_BINS));
                    check_count(out_count, exp_hist[ro_frame][word_cnt]);
                    if (out_count > MAX_FRAME_COUNT) begin
                        $display("count %0d at %0t is above the frame maximum", out_count,
                                 $time);
                        val_errs++;
                    end
                    word_cnt++;
                    if (word_cnt == HIS_DEPTH) begin
                        word_cnt = 0;
                        ro_frame++;
                    end
                end
            end else if (word_cnt != 0) begin
                $display("stream of frame %0d broke off after %0d words", ro_frame, word_cnt);
                stream_errs++;
                word_cnt = 0;
                ro_frame++;
            end
        end
    end

    // frame end pulse and bank toggle
    always @(negedge clk) begin
        int extra;
        if (res === 1'b1) begin
            if (tdc_valid) begin
                samples_seen++;
            end
            if (frame_done) begin
                done_cnt++;
                exp_bank = ~exp_bank;
                // next frame may already have up to three samples in
                extra = samples_seen - done_cnt * FRAME_SAMPLES;
                if (extra < 0 || extra > 3) begin
                    $display("frame_done %0d came after %0d samples", done_cnt, samples_seen);
                    frame_errs++;
                end
                if (fd_prev) begin
                    $display("frame_done stayed high for more than one cycle at %0t", $time);
                    frame_errs++;
                end
            end
            fd_prev = frame_done;
            check_bank(bank, exp_bank);
        end
    end

    initial begin
        int f;
        int s;
        int gap;
        int seed_dummy;
        int clr_cycles;
        tdc_code_t code;
        logic [BIN_W:0] rb;
        pixel_t pix;
        his_addr_t idx;

        res       = 1'b0;
        tdc_valid = 1'b0;
        tdc_code  = '0;
        clr_cycles = 0;
        seed_dummy = $urandom(57);

        repeat (15) @(posedge clk);
        @(negedge clk);
        // outputs in reset
        if (ready || frame_done || out_valid) begin
            $display("ready, frame_done or out_valid is high during reset");
            frame_errs++;
        end
        check_bank(bank, 1'b0);
        @(posedge clk);
        res <= 1'b1;

        // initial clear takes one cycle per word of both banks
        @(negedge clk);
        while (ready !== 1'b1) begin
            clr_cycles++;
            @(negedge clk);
        end
        if (clr_cycles != 2 * HIS_DEPTH) begin
            $display("ready rose after %0d clear cycles instead of %0d",
                     clr_cycles, 2 * HIS_DEPTH);
            frame_errs++;
        end

        for (f = 0; f < NUM_FRAMES; f++) begin
            for (s = 0; s < HIS_DEPTH; s++) begin
                exp_hist[f][s] = '0;
            end
            for (s = 0; s < FRAME_SAMPLES; s++) begin
                code = frame_code(f);
                // bursts run with no gaps to hit the forward path
                gap = (f == 2 || f == 4) ? 0 : $urandom_range(0, 3);
                pix = pixel_t'((s / SAMPLES_PER_PIXEL) % NUM_PIXELS);
                rb  = ref_bin(code);
                if (rb[BIN_W]) begin
                    idx = his_addr_t'(int'(pix) * NUM_BINS + int'(rb[BIN_W-1:0]));
                    if (exp_hist[f][idx] != 8'd255) begin
                        exp_hist[f][idx] = exp_hist[f][idx] + count_t'(1);
                    end
                end
                send_sample(code, gap);
            end
        end
        @(posedge clk);
        tdc_valid <= 1'b0;

        wait (ro_frame == NUM_FRAMES);
        repeat (8) @(posedge clk);
        if (done_cnt != NUM_FRAMES) begin
            $display("saw %0d frame_done pulses for %0d frames", done_cnt, NUM_FRAMES);
            frame_errs++;
        end

        $display("errors: values %0d, streams %0d, frames %0d",
                 val_errs, stream_errs, frame_errs);
        if (val_errs == 0 && stream_errs == 0 && frame_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* files.f */
his_pkg.sv
his_ram_if.sv
bin_mapper.sv
his_builder.sv
his_ram.sv
his_readout.sv
his_top.sv
tb_his_top.sv

/* Makefile */
all: run

run:
	verilator --binary --timing -f files.f --top-module tb_his_top -o sim_his
	./obj_dir/sim_his | tee /dev/stderr | grep -q -F '*** PASSED ***'

lint:
	verilator --lint-only -Wall --top-module his_top \
		his_pkg.sv his_ram_if.sv bin_mapper.sv his_builder.sv \
		his_ram.sv his_readout.sv his_top.sv

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
